//--- verilog/ssa_defs.svh
`ifndef SSA_DEFS_SVH
`define SSA_DEFS_SVH

// router geometry
`define SSA_P 5     // local, east, north, west, south
`define SSA_V 2     // virtual channels per port

// flit format
`define SSA_FW 32
`define SSA_DSTPW 3 // encoded destination port

// field positions inside a flit
`define SSA_HDR_BIT 31
`define SSA_TAIL_BIT 30
`define SSA_VC_LSB 28  // one-hot vc, SSA_V bits wide
`define SSA_DST_LSB 25 // header flits only

`endif

//--- verilog/ssa_flit_pkg.sv
`include "ssa_defs.svh"

package ssa_flit_pkg;

    // code is {hdr flag, tail flag}
    typedef enum logic [1:0] {
        FLIT_BODY   = 2'b00,
        FLIT_TAIL   = 2'b01,
        FLIT_HDR    = 2'b10,
        FLIT_SINGLE = 2'b11
    } flit_kind_e;

    typedef logic [`SSA_FW-1:0] flit_t;

    typedef logic [`SSA_V-1:0] vc_onehot_t;

    // header flag set, single-flit packets included
    function automatic logic is_hdr(input flit_kind_e kind);
        return (kind == FLIT_HDR) || (kind == FLIT_SINGLE);
    endfunction

    // tail flag set, single-flit packets included
    function automatic logic is_tail(input flit_kind_e kind);
        return (kind == FLIT_TAIL) || (kind == FLIT_SINGLE);
    endfunction

    function automatic logic is_single(input flit_kind_e kind);
        return kind == FLIT_SINGLE;
    endfunction

endpackage

//--- verilog/ssa_router_pkg.sv
`include "ssa_defs.svh"

package ssa_router_pkg;

    typedef enum logic [2:0] {
        PORT_LOCAL = 3'd0,
        PORT_EAST  = 3'd1,
        PORT_NORTH = 3'd2,
        PORT_WEST  = 3'd3,
        PORT_SOUTH = 3'd4,
        PORT_NONE  = 3'd5 // no straight port
    } port_e;

    // opposite port in the mesh, the local port has none
    function automatic port_e straight_port(input port_e p);
        port_e ss;
        case (p)
            PORT_EAST:  ss = PORT_WEST;
            PORT_WEST:  ss = PORT_EAST;
            PORT_NORTH: ss = PORT_SOUTH;
            PORT_SOUTH: ss = PORT_NORTH;
            default:    ss = PORT_NONE;
        endcase
        return ss;
    endfunction

    // encoded destination against the straight port of sw_loc
    function automatic logic dst_is_straight(
        input port_e                  sw_loc,
        input logic [`SSA_DSTPW-1:0] dst
    );
        port_e ss;
        ss = straight_port(sw_loc);
        return (ss != PORT_NONE) && (dst == ss);
    endfunction

endpackage

//--- verilog/ssa_flit_decode.sv
`include "ssa_defs.svh"

module ssa_flit_decode #(
    parameter ssa_router_pkg::port_e SW_LOC = ssa_router_pkg::PORT_EAST
) (
    input  ssa_flit_pkg::flit_t                flit_in_i,
    input  logic                               flit_in_wr_i,
    input  logic [`SSA_V*`SSA_DSTPW-1:0]       ivc_dest_port_i, // buffered packets
    output ssa_flit_pkg::flit_kind_e           flit_kind_o,
    output ssa_flit_pkg::vc_onehot_t           vc_wr_o,
    output logic                               hdr_to_ss_o,
    output logic [`SSA_V-1:0]                  nonhdr_to_ss_o
);
    import ssa_flit_pkg::*;
    import ssa_router_pkg::*;

    localparam int V = `SSA_V;

    logic                   hdr_flg;
    logic                   tail_flg;
    vc_onehot_t             vc_num;
    logic [`SSA_DSTPW-1:0]  dst_in; // only meaningful in header flits

    assign hdr_flg  = flit_in_i[`SSA_HDR_BIT];
    assign tail_flg = flit_in_i[`SSA_TAIL_BIT];
    assign vc_num   = flit_in_i[`SSA_VC_LSB +: V];
    assign dst_in   = flit_in_i[`SSA_DST_LSB +: `SSA_DSTPW];

    assign flit_kind_o = flit_kind_e'({hdr_flg, tail_flg});

    // vc strobe only while the link writes
    assign vc_wr_o = vc_num & {V{flit_in_wr_i}};

    assign hdr_to_ss_o = dst_is_straight(SW_LOC, dst_in);

    genvar v;
    generate
        for (v = 0; v < V; v = v + 1) begin : g_ivc
            // body and tail flits follow the destination latched in the ivc
            assign nonhdr_to_ss_o[v] =
                dst_is_straight(SW_LOC, ivc_dest_port_i[v*`SSA_DSTPW +: `SSA_DSTPW]);
        end
    endgenerate

    // a written flit addresses exactly one vc, the execute stage relies on it
    always_comb begin
        vc_onehot_a: assert ($onehot0(vc_wr_o))
        else $error("flit on port %0d written to several vcs %b", SW_LOC, vc_wr_o);
    end

endmodule

//--- verilog/ssa_vc_execute.sv
`include "ssa_defs.svh"

module ssa_vc_execute #(
    parameter int VC_ID = 0
) (
    input  ssa_flit_pkg::flit_kind_e  flit_kind_i,
    input  ssa_flit_pkg::vc_onehot_t  vc_wr_i,
    input  logic                      hdr_to_ss_i,
    input  logic                      nonhdr_to_ss_i,
    input  logic                      any_ovc_granted_in_ss_port_i,
    input  logic                      any_ivc_sw_request_granted_i,
    input  logic                      ovc_avalable_in_ss_port_i,
    input  logic                      ovc_full_in_ss_port_i,
    input  logic                      ivc_req_i,
    input  logic                      ivc_ovc_is_assigned_i,
    input  logic                      assigned_to_ss_ovc_i,
    output logic                      sw_grant_o,
    output logic                      ovc_grant_o,
    output logic                      ivc_reset_o,
    output logic                      single_flit_pck_o,
    output logic                      ovc_allocated_o,
    output logic                      ovc_released_o,
    output logic [`SSA_V-1:0]         granted_ovc_num_o
);
    import ssa_flit_pkg::*;

    logic vc_wr;
    logic hdr;
    logic single;
    logic ss_ovc_ready;
    logic permitted;

    assign vc_wr  = vc_wr_i[VC_ID];
    assign hdr    = is_hdr(flit_kind_i);
    assign single = is_single(flit_kind_i);

    // packet already owns an ovc, it must be the straight one and have room
    always_comb begin
        if (ivc_ovc_is_assigned_i) begin
            ss_ovc_ready = nonhdr_to_ss_i & assigned_to_ss_ovc_i & ~ovc_full_in_ss_port_i;
        end else begin
            ss_ovc_ready = ovc_avalable_in_ss_port_i;
        end
    end

    assign permitted = ss_ovc_ready & ~ivc_req_i
                     & ~any_ovc_granted_in_ss_port_i
                     & ~any_ivc_sw_request_granted_i;

    // header heading elsewhere is left to the normal allocators
    assign sw_grant_o  = vc_wr & permitted & ~(hdr & ~hdr_to_ss_i);
    assign ovc_grant_o = vc_wr & permitted & hdr & hdr_to_ss_i;
    assign ivc_reset_o = sw_grant_o & is_tail(flit_kind_i);

    assign single_flit_pck_o = vc_wr & single;

    // single flit packets never hold the ovc
    assign ovc_allocated_o = ovc_grant_o & ~single;
    assign ovc_released_o  = ivc_reset_o & ~single;

    always_comb begin
        granted_ovc_num_o        = '0;
        granted_ovc_num_o[VC_ID] = ovc_grant_o; // same vc number in the straight port
    end

    always_comb begin
        single_no_hold_a: assert (!(single_flit_pck_o && (ovc_allocated_o || ovc_released_o)))
        else $error("single flit on vc %0d allocated or released its ovc", VC_ID);
    end

endmodule

//--- verilog/ssa_port_result.sv
`include "ssa_defs.svh"

module ssa_port_result (
    input  logic                clk,
    input  logic                arst_n_i,
    input  logic [`SSA_V-1:0]   sw_grant_i,        // from the opposite input port
    input  logic [`SSA_V-1:0]   ovc_allocated_i,
    input  logic [`SSA_V-1:0]   ovc_released_i,
    input  logic [`SSA_V-1:0]   single_flit_pck_i,
    output logic [`SSA_V-1:0]   ovc_allocated_o,
    output logic [`SSA_V-1:0]   ovc_released_o,
    output logic [`SSA_V-1:0]   buff_space_decreased_o,
    output logic [`SSA_V-1:0]   ovc_single_flit_pck_o,
    output logic                ssa_flit_wr_o
);

    logic any_grant;

    // ivc v of the opposite port lands in ovc v here
    assign ovc_allocated_o        = ovc_allocated_i;
    assign ovc_released_o         = ovc_released_i;
    assign buff_space_decreased_o = sw_grant_i;        // one credit per forwarded flit
    assign ovc_single_flit_pck_o  = single_flit_pck_i & sw_grant_i;

    assign any_grant = |sw_grant_i;

    // flit reaches the crossbar one cycle after the grant
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ssa_flit_wr_o <= 1'b0;
        end else begin
            ssa_flit_wr_o <= any_grant;
        end
    end

    // one flit per input link per cycle means at most one vc can win
    grant_onehot_a: assert property (@(posedge clk) disable iff (!arst_n_i)
        $onehot0(sw_grant_i))
    else $error("several straight grants into one output port %b", sw_grant_i);

endmodule

//--- verilog/ssa_allocator.sv
`include "ssa_defs.svh"

module ssa_allocator (
    input  logic                                  clk,
    input  logic                                  arst_n_i,
    input  logic [`SSA_P-1:0]                     flit_in_wr_i,
    input  logic [`SSA_P*`SSA_FW-1:0]             flit_in_i,
    input  logic [`SSA_P-1:0]                     any_ovc_granted_in_outport_i,
    input  logic [`SSA_P-1:0]                     any_ivc_sw_request_granted_i,
    input  logic [`SSA_P*`SSA_V-1:0]              ovc_avalable_i,
    input  logic [`SSA_P*`SSA_V-1:0]              ovc_full_i,
    input  logic [`SSA_P*`SSA_V-1:0]              ivc_req_i,
    input  logic [`SSA_P*`SSA_V-1:0]              ivc_ovc_is_assigned_i,
    input  logic [`SSA_P*`SSA_V*`SSA_V-1:0]       ivc_assigned_ovc_i,
    input  logic [`SSA_P*`SSA_V*`SSA_DSTPW-1:0]   ivc_dest_port_i,
    output logic [`SSA_P*`SSA_V-1:0]              ovc_allocated_o,
    output logic [`SSA_P*`SSA_V-1:0]              ovc_released_o,
    output logic [`SSA_P*`SSA_V-1:0]              buff_space_decreased_o,
    output logic [`SSA_P*`SSA_V-1:0]              ivc_sw_grant_o,
    output logic [`SSA_P*`SSA_V-1:0]              ivc_ovc_grant_o,
    output logic [`SSA_P*`SSA_V-1:0]              ivc_reset_o,
    output logic [`SSA_P*`SSA_V-1:0]              ivc_single_flit_pck_o,
    output logic [`SSA_P*`SSA_V-1:0]              ovc_single_flit_pck_o,
    output logic [`SSA_P*`SSA_V*`SSA_V-1:0]       ivc_granted_ovc_num_o,
    output logic [`SSA_P-1:0]                     ssa_flit_wr_o
);
    import ssa_flit_pkg::*;
    import ssa_router_pkg::*;

    localparam int P = `SSA_P;
    localparam int V = `SSA_V;

    logic [P*V-1:0] ivc_alloc; // per ivc, before remap onto output ports
    logic [P*V-1:0] ivc_rel;

    // local port never goes straight
    assign ivc_sw_grant_o[V-1:0]          = '0;
    assign ivc_ovc_grant_o[V-1:0]         = '0;
    assign ivc_reset_o[V-1:0]             = '0;
    assign ivc_single_flit_pck_o[V-1:0]   = '0;
    assign ivc_granted_ovc_num_o[V*V-1:0] = '0;
    assign ivc_alloc[V-1:0]               = '0;
    assign ivc_rel[V-1:0]                 = '0;
    assign ovc_allocated_o[V-1:0]         = '0;
    assign ovc_released_o[V-1:0]          = '0;
    assign buff_space_decreased_o[V-1:0]  = '0;
    assign ovc_single_flit_pck_o[V-1:0]   = '0;
    assign ssa_flit_wr_o[0]               = 1'b0;

    genvar p, v;
    generate
        for (p = 1; p < P; p = p + 1) begin : g_port
            localparam port_e SW_LOC = port_e'(p);
            localparam int    SS     = straight_port(SW_LOC); // also the source of output p

            flit_kind_e       flit_kind;
            vc_onehot_t       vc_wr;
            logic             hdr_to_ss;
            logic [V-1:0]     nonhdr_to_ss;

            ssa_flit_decode #(
                .SW_LOC(SW_LOC)
            ) u_decode (
                .flit_in_i       (flit_in_i[p*`SSA_FW +: `SSA_FW]),
                .flit_in_wr_i    (flit_in_wr_i[p]),
                .ivc_dest_port_i (ivc_dest_port_i[p*V*`SSA_DSTPW +: V*`SSA_DSTPW]),
                .flit_kind_o     (flit_kind),
                .vc_wr_o         (vc_wr),
                .hdr_to_ss_o     (hdr_to_ss),
                .nonhdr_to_ss_o  (nonhdr_to_ss)
            );

            for (v = 0; v < V; v = v + 1) begin : g_vc
                ssa_vc_execute #(
                    .VC_ID(v)
                ) u_execute (
                    .flit_kind_i                  (flit_kind),
                    .vc_wr_i                      (vc_wr),
                    .hdr_to_ss_i                  (hdr_to_ss),
                    .nonhdr_to_ss_i               (nonhdr_to_ss[v]),
                    .any_ovc_granted_in_ss_port_i (any_ovc_granted_in_outport_i[SS]),
                    .any_ivc_sw_request_granted_i (any_ivc_sw_request_granted_i[p]),
                    .ovc_avalable_in_ss_port_i    (ovc_avalable_i[SS*V+v]),
                    .ovc_full_in_ss_port_i        (ovc_full_i[SS*V+v]),
                    .ivc_req_i                    (ivc_req_i[p*V+v]),
                    .ivc_ovc_is_assigned_i        (ivc_ovc_is_assigned_i[p*V+v]),
                    .assigned_to_ss_ovc_i         (ivc_assigned_ovc_i[(p*V+v)*V+v]),
                    .sw_grant_o                   (ivc_sw_grant_o[p*V+v]),
                    .ovc_grant_o                  (ivc_ovc_grant_o[p*V+v]),
                    .ivc_reset_o                  (ivc_reset_o[p*V+v]),
                    .single_flit_pck_o            (ivc_single_flit_pck_o[p*V+v]),
                    .ovc_allocated_o              (ivc_alloc[p*V+v]),
                    .ovc_released_o               (ivc_rel[p*V+v]),
                    .granted_ovc_num_o            (ivc_granted_ovc_num_o[(p*V+v)*V +: V])
                );
            end

            // output port p is fed by the input port opposite to it
            ssa_port_result u_result (
                .clk                    (clk),
                .arst_n_i               (arst_n_i),
                .sw_grant_i             (ivc_sw_grant_o[SS*V +: V]),
                .ovc_allocated_i        (ivc_alloc[SS*V +: V]),
                .ovc_released_i         (ivc_rel[SS*V +: V]),
                .single_flit_pck_i      (ivc_single_flit_pck_o[SS*V +: V]),
                .ovc_allocated_o        (ovc_allocated_o[p*V +: V]),
                .ovc_released_o         (ovc_released_o[p*V +: V]),
                .buff_space_decreased_o (buff_space_decreased_o[p*V +: V]),
                .ovc_single_flit_pck_o  (ovc_single_flit_pck_o[p*V +: V]),
                .ssa_flit_wr_o          (ssa_flit_wr_o[p])
            );
        end
    endgenerate

endmodule

//--- verification/tb_clk_gen.sv
module tb_clk_gen (
    output logic clk_o,
    output logic arst_n_o
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk_o = 1'b0;
        forever #10 clk_o = ~clk_o; // 20 ns period
    end

    initial begin
        arst_n_o = 1'b0;
        repeat (5) @(posedge clk_o);
        arst_n_o <= 1'b1;
    end

endmodule

//--- verification/tb_ssa_allocator.sv
`include "ssa_defs.svh"

module tb_ssa_allocator;
    timeunit 1ns;
    timeprecision 1ps;
    import ssa_flit_pkg::*;
    import ssa_router_pkg::*;

    localparam int P = `SSA_P;
    localparam int V = `SSA_V;
    localparam int FW = `SSA_FW;
    localparam int DW = `SSA_DSTPW;
    localparam int MAX_CYCLES = 1000;

    logic clk, arst_n;
    logic [P-1:0] flit_in_wr, any_ovc_granted, any_ivc_sw_granted, ssa_flit_wr;
    logic [P*FW-1:0] flit_in;
    logic [P*V-1:0] ovc_avalable, ovc_full, ivc_req, ivc_assigned;
    logic [P*V*V-1:0] ivc_assigned_ovc, granted_num;
    logic [P*V*DW-1:0] ivc_dest;
    logic [P*V-1:0] allocated, released, buff_dec, sw_grant, ovc_grant;
    logic [P*V-1:0] ivc_rst, ivc_single, ovc_single;

    // expected values from the reference model
    logic [P*V-1:0] exp_alloc, exp_rel, exp_buff, exp_sw, exp_ovc_grant;
    logic [P*V-1:0] exp_rst, exp_ivc_single, exp_ovc_single;
    logic [P*V*V-1:0] exp_num;
    logic [P-1:0] exp_wr_next, exp_wr_prev;

    logic [15:0] lfsr_state = 16'd50696;
    int errors = 0;
    int cycles = 0;

    tb_clk_gen u_clk (.clk_o(clk), .arst_n_o(arst_n));

    ssa_allocator uut (
        .clk(clk), .arst_n_i(arst_n),
        .flit_in_wr_i(flit_in_wr), .flit_in_i(flit_in),
        .any_ovc_granted_in_outport_i(any_ovc_granted),
        .any_ivc_sw_request_granted_i(any_ivc_sw_granted),
        .ovc_avalable_i(ovc_avalable), .ovc_full_i(ovc_full),
        .ivc_req_i(ivc_req), .ivc_ovc_is_assigned_i(ivc_assigned),
        .ivc_assigned_ovc_i(ivc_assigned_ovc), .ivc_dest_port_i(ivc_dest),
        .ovc_allocated_o(allocated), .ovc_released_o(released),
        .buff_space_decreased_o(buff_dec), .ivc_sw_grant_o(sw_grant),
        .ivc_ovc_grant_o(ovc_grant), .ivc_reset_o(ivc_rst),
        .ivc_single_flit_pck_o(ivc_single), .ovc_single_flit_pck_o(ovc_single),
        .ivc_granted_ovc_num_o(granted_num), .ssa_flit_wr_o(ssa_flit_wr)
    );

    // 16 bit fibonacci lfsr with taps 16 14 13 11
    function automatic logic rand_bit();
        logic fb;
        fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
        lfsr_state = {lfsr_state[14:0], fb};
        return fb;
    endfunction

    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] r;
        r = '0;
        for (int i = 0; i < n; i++) r[i] = rand_bit();
        return r;
    endfunction

    function automatic int opposite(input int p);
        case (p)
            1: return 3;
            3: return 1;
            2: return 4;
            4: return 2;
            default: return -1;
        endcase
    endfunction

    function automatic logic [FW-1:0] mk_flit(input flit_kind_e kind, input int vc,
                                              input logic [DW-1:0] dst);
        logic [FW-1:0] f;
        f = '0;
        f[31:30] = kind;
        f[28+vc] = 1'b1;
        f[27:25] = dst;
        return f;
    endfunction

    // straight allocation rules applied to the current inputs
    function automatic void compute_expected();
        int ss, i;
        logic [FW-1:0] f;
        logic hdr, tail, single, wr_vc, hdr_ss, buf_ss, ready, perm, grant, og, rst;
        exp_alloc = '0;
        exp_rel = '0;
        exp_buff = '0;
        exp_sw = '0;
        exp_ovc_grant = '0;
        exp_rst = '0;
        exp_ivc_single = '0;
        exp_ovc_single = '0;
        exp_num = '0;
        exp_wr_next = '0;
        for (int p = 1; p < P; p++) begin
            ss = opposite(p);
            f = flit_in[p*FW +: FW];
            hdr = f[31];
            tail = f[30];
            single = hdr & tail;
            hdr_ss = (f[27:25] == DW'(ss));
            for (int v = 0; v < V; v++) begin
                i = p*V + v;
                wr_vc = flit_in_wr[p] & f[28+v];
                buf_ss = (ivc_dest[i*DW +: DW] == DW'(ss));
                if (ivc_assigned[i])
                    ready = buf_ss & ivc_assigned_ovc[i*V+v] & ~ovc_full[ss*V+v];
                else
                    ready = ovc_avalable[ss*V+v];
                perm = ready & ~ivc_req[i] & ~any_ovc_granted[ss] & ~any_ivc_sw_granted[p];
                grant = wr_vc & perm & (~hdr | hdr_ss);
                og = wr_vc & perm & hdr & hdr_ss;
                rst = grant & tail;
                exp_sw[i] = grant;
                exp_ovc_grant[i] = og;
                exp_rst[i] = rst;
                exp_ivc_single[i] = wr_vc & single;
                exp_num[i*V+v] = og;
                exp_alloc[ss*V+v] = og & ~single;
                exp_rel[ss*V+v] = rst & ~single;
                exp_buff[ss*V+v] = grant;
                exp_ovc_single[ss*V+v] = wr_vc & single & grant;
                exp_wr_next[ss] = exp_wr_next[ss] | grant;
            end
        end
    endfunction

    task automatic check(input string name, input logic [63:0] exp, input logic [63:0] got);
        assert (got === exp)
        else begin
            errors++;
            $display("** Error %s expected %h got %h at %0t", name, exp, got, $time);
        end
    endtask

    // compare every output with the model at the falling edge
    always @(negedge clk) begin
        compute_expected();
        check("ivc_sw_grant_o", 64'(exp_sw), 64'(sw_grant));
        check("ivc_ovc_grant_o", 64'(exp_ovc_grant), 64'(ovc_grant));
        check("ivc_reset_o", 64'(exp_rst), 64'(ivc_rst));
        check("ivc_single_flit_pck_o", 64'(exp_ivc_single), 64'(ivc_single));
        check("ivc_granted_ovc_num_o", 64'(exp_num), 64'(granted_num));
        check("ovc_allocated_o", 64'(exp_alloc), 64'(allocated));
        check("ovc_released_o", 64'(exp_rel), 64'(released));
        check("buff_space_decreased_o", 64'(exp_buff), 64'(buff_dec));
        check("ovc_single_flit_pck_o", 64'(exp_ovc_single), 64'(ovc_single));
        check("ssa_flit_wr_o", 64'(exp_wr_prev), 64'(ssa_flit_wr));
        exp_wr_prev = arst_n ? exp_wr_next : '0; // strobe lags one cycle
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("TEST FAIL");
            $finish;
        end
    end

    task automatic clear_inputs();
        flit_in_wr <= '0;
        flit_in <= '0;
        any_ovc_granted <= '0;
        any_ivc_sw_granted <= '0;
        ovc_avalable <= '0;
        ovc_full <= '0;
        ivc_req <= '0;
        ivc_assigned <= '0;
        ivc_assigned_ovc <= '0;
        ivc_dest <= '0;
    endtask

    // header on west vc0 heading east with east ovc0 free
    task automatic drive_west_hdr(input flit_kind_e kind);
        flit_in_wr[PORT_WEST] <= 1'b1;
        flit_in[PORT_WEST*FW +: FW] <= mk_flit(kind, 0, PORT_EAST);
        ovc_avalable[PORT_EAST*V] <= 1'b1;
    endtask

    // west ivc0 holds east ovc0
    task automatic drive_west_assigned(input flit_kind_e kind, input logic full);
        flit_in_wr[PORT_WEST] <= 1'b1;
        flit_in[PORT_WEST*FW +: FW] <= mk_flit(kind, 0, 3'd0);
        ivc_assigned[PORT_WEST*V] <= 1'b1;
        ivc_assigned_ovc[PORT_WEST*V*V] <= 1'b1;
        ivc_dest[PORT_WEST*V*DW +: DW] <= PORT_EAST;
        ovc_full[PORT_EAST*V] <= full;
    endtask

    task automatic random_cycle();
        logic [P*FW-1:0] f;
        logic [FW-1:0] one;
        for (int p = 0; p < P; p++) begin
            one = FW'(rand_bits(FW));
            one[29:28] = rand_bit() ? 2'b10 : 2'b01; // one vc per flit
            f[p*FW +: FW] = one;
        end
        flit_in <= f;
        flit_in_wr <= P'(rand_bits(P));
        any_ovc_granted <= P'(rand_bits(P) & rand_bits(P)); // rarer blocks
        any_ivc_sw_granted <= P'(rand_bits(P) & rand_bits(P));
        ovc_avalable <= (P*V)'(rand_bits(P*V));
        ovc_full <= (P*V)'(rand_bits(P*V));
        ivc_req <= (P*V)'(rand_bits(P*V) & rand_bits(P*V));
        ivc_assigned <= (P*V)'(rand_bits(P*V));
        ivc_assigned_ovc <= (P*V*V)'(rand_bits(P*V*V));
        ivc_dest <= (P*V*DW)'(rand_bits(P*V*DW));
    endtask

    initial begin
        clear_inputs();
        exp_wr_prev = '0;
        wait (arst_n === 1'b1);
        repeat (2) @(posedge clk);

        @(posedge clk);
        clear_inputs();
        drive_west_hdr(FLIT_HDR);
        @(negedge clk);
        check("ivc_sw_grant_o[west0]", 1, 64'(sw_grant[PORT_WEST*V]));
        check("ivc_ovc_grant_o[west0]", 1, 64'(ovc_grant[PORT_WEST*V]));
        check("ovc_allocated_o[east0]", 1, 64'(allocated[PORT_EAST*V]));
        @(posedge clk);
        clear_inputs();
        @(negedge clk);
        check("ssa_flit_wr_o[east]", 1, 64'(ssa_flit_wr[PORT_EAST]));

        for (int k = 0; k < 4; k++) begin
            @(posedge clk);
            clear_inputs();
            drive_west_hdr(FLIT_HDR);
            case (k)
                0: any_ovc_granted[PORT_EAST] <= 1'b1;
                1: any_ivc_sw_granted[PORT_WEST] <= 1'b1;
                2: ivc_req[PORT_WEST*V] <= 1'b1;
                default: flit_in[PORT_WEST*FW +: FW] <= mk_flit(FLIT_HDR, 0, PORT_NORTH);
            endcase
            @(negedge clk);
            check("ivc_sw_grant_o[west0] blocked", 0, 64'(sw_grant[PORT_WEST*V]));
        end

        @(posedge clk);
        clear_inputs();
        drive_west_assigned(FLIT_BODY, 1'b0);
        @(negedge clk);
        check("ivc_sw_grant_o[west0] body", 1, 64'(sw_grant[PORT_WEST*V]));
        check("buff_space_decreased_o[east0]", 1, 64'(buff_dec[PORT_EAST*V]));
        @(posedge clk);
        clear_inputs();
        drive_west_assigned(FLIT_TAIL, 1'b0);
        @(negedge clk);
        check("ivc_reset_o[west0] tail", 1, 64'(ivc_rst[PORT_WEST*V]));
        check("ovc_released_o[east0]", 1, 64'(released[PORT_EAST*V]));
        @(posedge clk);
        clear_inputs();
        drive_west_assigned(FLIT_BODY, 1'b1);
        @(negedge clk);
        check("ivc_sw_grant_o[west0] full body", 0, 64'(sw_grant[PORT_WEST*V]));
        @(posedge clk);
        clear_inputs();
        drive_west_assigned(FLIT_TAIL, 1'b1);
        @(negedge clk);
        check("ivc_sw_grant_o[west0] full tail", 0, 64'(sw_grant[PORT_WEST*V]));

        @(posedge clk);
        clear_inputs();
        drive_west_hdr(FLIT_SINGLE);
        @(negedge clk);
        check("ivc_sw_grant_o[west0] single", 1, 64'(sw_grant[PORT_WEST*V]));
        check("ivc_reset_o[west0] single", 1, 64'(ivc_rst[PORT_WEST*V]));
        check("ivc_single_flit_pck_o[west0]", 1, 64'(ivc_single[PORT_WEST*V]));
        check("ovc_single_flit_pck_o[east0]", 1, 64'(ovc_single[PORT_EAST*V]));
        check("ovc_allocated_o[east0] single", 0, 64'(allocated[PORT_EAST*V]));
        check("ovc_released_o[east0] single", 0, 64'(released[PORT_EAST*V]));

        repeat (400) begin
            @(posedge clk);
            random_cycle();
        end
        @(posedge clk);
        clear_inputs();
        repeat (2) @(negedge clk);
        @(posedge clk);

        $display("errors: %0d mismatches after %0d cycles", errors, cycles);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

//--- sim.f
+incdir+verilog
verilog/ssa_flit_pkg.sv
verilog/ssa_router_pkg.sv
verilog/ssa_flit_decode.sv
verilog/ssa_vc_execute.sv
verilog/ssa_port_result.sv
verilog/ssa_allocator.sv
verification/tb_clk_gen.sv
verification/tb_ssa_allocator.sv

//--- run_sim.sh
#!/bin/sh
# builds the testbench with Verilator and runs it, pass only if TEST PASS shows up
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/1ps \
    -f sim.f --top-module tb_ssa_allocator -o sim_tb_ssa_allocator &&
./obj_dir/sim_tb_ssa_allocator | tee /dev/stderr | grep -q "TEST PASS" ||
{ echo "simulation failed"; exit 1; }
